/* logic/alu_pkg.sv */
// shared widths, encodings and iteration constants of the iterative fixed-point unit
// fractions are 8-bit binary (y/256); operands and results are 13-bit unsigned
package alu_pkg;

    ///////////////////////////////
    // widths
    ///////////////////////////////
    localparam int operand_w  = 13;   // x, y and result
    localparam int quotient_w = 9;    // cf quotients reach 511
    localparam int frac_bits  = 8;    // multiplier fraction, y/256
    localparam int acc_w      = 21;   // holds 8191 * 255 exactly

    typedef logic [operand_w-1:0]  operand_t;
    typedef logic [quotient_w-1:0] quotient_t;
    typedef logic [1:0]            alu_mode_t;
    typedef logic [3:0]            step_cnt_t;

    typedef enum logic {
        op_mul = 1'b0,
        op_div = 1'b1
    } alu_op_t;

    // multiplier modes
    localparam alu_mode_t mode_pure   = 2'd0;  // floor(x*y/256)
    localparam alu_mode_t mode_frac   = 2'd1;  // x + floor(x*y/256)
    localparam alu_mode_t mode_double = 2'd2;  // 2x bound, code 3 acts the same

    // divider modes
    localparam alu_mode_t mode_sa     = 2'd0;  // x < y, 8 quotient bits
    localparam alu_mode_t mode_cf_t27 = 2'd1;  // x*128/y
    localparam alu_mode_t mode_cf_t36 = 2'd2;  // x*64/y, code 3 acts the same

    typedef enum logic [1:0] {
        st_idle,   // waiting for a request
        st_load,   // datapaths and counter take their start values
        st_run,    // one iteration per cycle
        st_hold    // result offered until taken
    } seq_state_t;

    ///////////////////////////////
    // iteration counts
    ///////////////////////////////
    localparam step_cnt_t mul_iters    = 4'd8;
    localparam step_cnt_t div_iters_sa = 4'd8;
    localparam step_cnt_t div_iters_cf = 4'd9;

    // cf saturation results, used when x/4 >= y
    localparam quotient_t sat_t27 = 9'd511;
    localparam quotient_t sat_t36 = 9'd256;

    // dividend pre-shift of each cf mode
    localparam int shift_t27 = 7;
    localparam int shift_t36 = 6;

endpackage

/* logic/alu_sequencer.sv */
// one operation in flight: in_ready only in idle, out_valid only in hold
// op and mode are latched on the accepting edge and held until the next one
// saturate must be valid during st_load since it picks the step count
`timescale 1ns/1ns

module alu_sequencer (
    input  logic               CLK,
    input  logic               RST_N,
    input  logic               in_valid,
    output logic               in_ready,
    input  alu_pkg::alu_op_t   op,
    input  alu_pkg::alu_mode_t mode,
    input  logic               saturate,   // cf quotient is out of range
    input  logic               last,       // from the step counter
    output logic               load,
    output logic               step_en,
    output alu_pkg::step_cnt_t count,
    output alu_pkg::alu_op_t   op_q,
    output alu_pkg::alu_mode_t mode_q,
    output logic               out_valid,
    input  logic               out_ready
);

    import alu_pkg::*;

    seq_state_t state_q;
    seq_state_t state_d;

    //////////////////////////////
    // step count selection
    //////////////////////////////
    always_comb begin
        if (op_q == op_mul) begin
            // doubling needs no iteration at all
            if ((mode_q == mode_pure) || (mode_q == mode_frac)) begin
                count = mul_iters;
            end else begin
                count = '0;
            end
        end else if (saturate) begin
            count = '0;   // quotient placed directly by the load
        end else if (mode_q == mode_sa) begin
            count = div_iters_sa;
        end else begin
            count = div_iters_cf;
        end
    end

    //////////////////////////////
    // handshake FSM
    //////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (in_valid) begin
                    state_d = st_load;
                end
            end
            st_load: begin
                // zero steps go straight to the result
                state_d = (count == '0) ? st_hold : st_run;
            end
            st_run: begin
                if (last) begin
                    state_d = st_hold;   // this edge runs the final step
                end
            end
            st_hold: begin
                if (out_ready) begin
                    state_d = st_idle;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state_q <= st_idle;
            op_q    <= op_mul;
            mode_q  <= mode_pure;
        end else begin
            state_q <= state_d;
            if (in_valid && in_ready) begin   // accepting edge
                op_q   <= op;
                mode_q <= mode;
            end
        end
    end

    assign in_ready  = (state_q == st_idle);
    assign load      = (state_q == st_load);
    assign step_en   = (state_q == st_run);   // one datapath step per cycle
    assign out_valid = (state_q == st_hold);

endmodule

/* logic/alu_step_counter.sv */
// shared loop bound for both datapaths; count is sampled only on load
// last stays high at zero so a zero-step load reads as already finished
`timescale 1ns/1ns

module alu_step_counter (
    input  logic              CLK,
    input  logic              RST_N,
    input  logic              load,      // take a new bound
    input  logic              step_en,   // one iteration done this cycle
    input  alu_pkg::step_cnt_t count,    // bound for the coming operation
    output logic              last       // current step is the final one
);

    import alu_pkg::*;

    step_cnt_t cnt_q;   // steps still to run

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            cnt_q <= '0;
        end else if (load) begin
            cnt_q <= count;
        end else if (step_en && (cnt_q != '0)) begin
            cnt_q <= cnt_q - step_cnt_t'(1);   // no wrap below zero
        end
    end

    // 1 -> this edge runs the final step, 0 -> nothing left at all
    assign last = (cnt_q < step_cnt_t'(2));

endmodule

/* logic/restoring_divider.sv */
// restoring division, one quotient bit per step, MSB first
// sa assumes x < y; a zero divisor there yields all ones (255)
// saturate is combinational from the inputs, so they must be stable during load
`timescale 1ns/1ns

module restoring_divider (
    input  logic               CLK,
    input  logic               RST_N,
    input  logic               load,
    input  logic               step_en,
    input  alu_pkg::alu_mode_t mode,
    input  alu_pkg::operand_t  x_in,      // dividend
    input  alu_pkg::operand_t  y_in,      // divisor
    output logic               saturate,  // cf quotient would not fit
    output alu_pkg::quotient_t quotient
);

    import alu_pkg::*;

    operand_t                  rem_q;     // partial remainder, always < divisor
    quotient_t                 dvd_q;     // dividend bits still to bring down
    quotient_t                 quo_q;
    operand_t                  div_q;     // divisor held for the steps
    logic [operand_w+quotient_w-1:0] x_wide;
    logic [operand_w:0]        trial;     // remainder after the shift
    logic                      fits;

    // x/4 >= y covers y == 0 as well
    assign saturate = (mode != mode_sa) && ({2'b00, x_in[operand_w-1:2]} >= y_in);

    assign x_wide = {{quotient_w{1'b0}}, x_in};

    //////////////////////////////
    // one restoring step
    //////////////////////////////
    assign trial = {rem_q, dvd_q[quotient_w-1]};   // shift left, next dividend bit in
    assign fits  = (trial >= {1'b0, div_q});

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            rem_q <= '0;
            dvd_q <= '0;
            quo_q <= '0;
            div_q <= '0;
        end else if (load) begin
            div_q <= y_in;
            quo_q <= '0;
            case (mode)
                mode_sa: begin
                    rem_q <= x_in;   // x*256 with 8 zero bits to come
                    dvd_q <= '0;
                end
                mode_cf_t27: begin
                    {rem_q, dvd_q} <= x_wide << shift_t27;   // x*128
                    if (saturate) begin
                        quo_q <= sat_t27;
                    end
                end
                default: begin                               // t36 and code 3
                    {rem_q, dvd_q} <= x_wide << shift_t36;   // x*64
                    if (saturate) begin
                        quo_q <= sat_t36;
                    end
                end
            endcase
        end else if (step_en) begin
            dvd_q <= {dvd_q[quotient_w-2:0], 1'b0};
            if (fits) begin
                rem_q <= operand_t'(trial - {1'b0, div_q});   // subtract
                quo_q <= {quo_q[quotient_w-2:0], 1'b1};
            end else begin
                rem_q <= trial[operand_w-1:0];   // restore, top bit is zero here
                quo_q <= {quo_q[quotient_w-2:0], 1'b0};
            end
        end
    end

    assign quotient = quo_q;

endmodule

/* logic/share_alu_top.sv */
// valid/ready wrapper around the shared multiply/divide datapaths
// operands are latched on acceptance; result holds until the next request
`timescale 1ns/1ns

module share_alu_top (
    input  logic               CLK,
    input  logic               RST_N,
    input  logic               in_valid,
    output logic               in_ready,
    input  alu_pkg::alu_op_t   op,
    input  alu_pkg::alu_mode_t mode,
    input  alu_pkg::operand_t  x_in,
    input  alu_pkg::operand_t  y_in,
    output logic               out_valid,
    input  logic               out_ready,
    output alu_pkg::operand_t  result
);

    import alu_pkg::*;

    operand_t  x_q;          // operands taken at the accepting edge
    operand_t  y_q;
    alu_op_t   op_q;
    alu_mode_t mode_q;
    step_cnt_t count;
    logic      load;
    logic      step_en;
    logic      last;
    logic      saturate;
    logic      mul_step;     // steps go only to the busy datapath
    logic      div_step;
    operand_t  product;
    quotient_t quotient;

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            x_q <= '0;
            y_q <= '0;
        end else if (in_valid && in_ready) begin
            x_q <= x_in;
            y_q <= y_in;
        end
    end

    assign mul_step = step_en && (op_q == op_mul);
    assign div_step = step_en && (op_q == op_div);

    //////////////////////////////
    // control
    //////////////////////////////
    alu_sequencer seq_i (
        .CLK(CLK), .RST_N(RST_N),
        .in_valid(in_valid), .in_ready(in_ready),
        .op(op), .mode(mode),
        .saturate(saturate), .last(last),
        .load(load), .step_en(step_en), .count(count),
        .op_q(op_q), .mode_q(mode_q),
        .out_valid(out_valid), .out_ready(out_ready)
    );

    alu_step_counter cnt_i (
        .CLK(CLK), .RST_N(RST_N),
        .load(load), .step_en(step_en), .count(count), .last(last)
    );

    //////////////////////////////
    // datapaths
    //////////////////////////////
    shift_add_multiplier mul_i (
        .CLK(CLK), .RST_N(RST_N),
        .load(load), .step_en(mul_step), .mode(mode_q),
        .x_in(x_q), .y_in(y_q), .product(product)
    );

    restoring_divider div_i (
        .CLK(CLK), .RST_N(RST_N),
        .load(load), .step_en(div_step), .mode(mode_q),
        .x_in(x_q), .y_in(y_q),
        .saturate(saturate), .quotient(quotient)
    );

    // quotient is 9 bits, zero-extended to the result width
    assign result = (op_q == op_div) ? {{(operand_w-quotient_w){1'b0}}, quotient} : product;

endmodule

/* logic/shift_add_multiplier.sv */
// exact shift-add product of x and the low 8 bits of y; no rounding inside
// product is valid after 8 steps (pure, frac) or right after load (doubling)
`timescale 1ns/1ns

module shift_add_multiplier (
    input  logic               CLK,
    input  logic               RST_N,
    input  logic               load,      // capture operands, clear accumulator
    input  logic               step_en,   // one multiplier bit per cycle
    input  alu_pkg::alu_mode_t mode,
    input  alu_pkg::operand_t  x_in,
    input  alu_pkg::operand_t  y_in,
    output alu_pkg::operand_t  product
);

    import alu_pkg::*;

    operand_t               x_q;        // multiplicand
    logic [frac_bits-1:0]   y_q;        // fraction bits of y
    logic [acc_w-1:0]       acc_q;      // running sum of shifted x
    logic [2:0]             bit_idx_q;  // multiplier bit of the current step
    logic [acc_w-1:0]       x_ext;
    logic [acc_w-1:0]       addend;
    operand_t               prod_frac;  // floor(x*y/256)

    assign x_ext  = {{(acc_w-operand_w){1'b0}}, x_q};
    assign addend = y_q[bit_idx_q] ? (x_ext << bit_idx_q) : '0;   // x * 2^i or nothing

    //////////////////////////////
    // accumulator
    //////////////////////////////
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            x_q       <= '0;
            y_q       <= '0;
            acc_q     <= '0;
            bit_idx_q <= '0;
        end else if (load) begin
            x_q       <= x_in;
            y_q       <= y_in[frac_bits-1:0];   // integer part of y is ignored
            acc_q     <= '0;
            bit_idx_q <= '0;
        end else if (step_en) begin
            acc_q     <= acc_q + addend;
            bit_idx_q <= bit_idx_q + 3'd1;      // wraps after bit 7, unused then
        end
    end

    // drop the 8 fraction bits, 8191*255 fits in the top 13
    assign prod_frac = acc_q[acc_w-1:frac_bits];

    //////////////////////////////
    // mode result
    //////////////////////////////
    always_comb begin
        case (mode)
            mode_pure: product = prod_frac;
            mode_frac: product = prod_frac + x_q;            // 1.f * x, wraps at 13 bits
            mode_double: product = {x_q[operand_w-2:0], 1'b0};
            default: product = {x_q[operand_w-2:0], 1'b0};   // code 3 = doubling
        endcase
    end

endmodule

/* testbench/share_alu_stim.txt */
# columns: op mode x y expected, all hex
# op 0 = multiply, 1 = divide; mode 3 behaves like mode 2
0 0 0100 0080 0080
0 0 1fff 00ff 1fdf
0 0 00ff 00ff 00fe
0 0 0123 0000 0000
0 0 0003 0055 0000
0 0 00a0 0040 0028
0 1 0100 0080 0180
0 1 1fff 00ff 1fde
0 1 0064 0000 0064
0 1 00c8 0033 00ef
0 1 1000 0001 1010
0 2 0123 0055 0246
0 2 1fff 0000 1ffe
0 3 0800 0010 1000
1 0 0001 0002 0080
1 0 0001 0003 0055
1 0 00fe 00ff 00fe
1 0 1ffe 1fff 00ff
1 0 0000 0010 0000
1 0 0005 0000 00ff
1 0 0000 0000 00ff
1 1 0064 0064 0080
1 1 000a 0003 01aa
1 1 0010 0004 01ff
1 1 0005 0000 01ff
1 1 1fff 0800 01ff
1 2 000a 0003 00d5
1 2 00c8 0032 0100
1 2 1fff 1fff 0040
1 3 0007 0002 00e0
1 3 0008 0002 0100

/* testbench/tb_share_alu.sv */
// vectors come from testbench/share_alu_stim.txt relative to the project root
// one request in flight at a time; outputs are sampled on the falling edge
`timescale 1ns/1ns

module tb_share_alu;

    import alu_pkg::*;

    localparam int n_random      = 200;   // random ops after the file
    localparam int cycles_per_op = 100;   // watchdog budget per operation
    localparam int reset_cycles  = 16;

    logic      CLK = 1'b0;
    logic      RST_N;
    logic      in_valid;
    logic      in_ready;
    alu_op_t   op;
    alu_mode_t mode;
    operand_t  x_in;
    operand_t  y_in;
    logic      out_valid;
    logic      out_ready;
    operand_t  result;

    logic [31:0] rng_state = 32'ha35;
    logic [31:0] vec_op[$];      // directed vectors from the file
    logic [31:0] vec_mode[$];
    logic [31:0] vec_x[$];
    logic [31:0] vec_y[$];
    logic [31:0] vec_exp[$];
    logic        stim_loaded = 1'b0;   // starts the watchdog
    int          error_count = 0;

    share_alu_top dut_i (
        .CLK(CLK), .RST_N(RST_N),
        .in_valid(in_valid), .in_ready(in_ready),
        .op(op), .mode(mode), .x_in(x_in), .y_in(y_in),
        .out_valid(out_valid), .out_ready(out_ready), .result(result)
    );

    always #20 CLK = ~CLK;   // 40 ns period

    //////////////////////////////
    // helpers
    //////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic draw_rand(output logic [31:0] v);
        rng_state = xorshift32(rng_state);
        v = rng_state;
    endtask

    // reference model straight from the arithmetic rules
    function automatic logic [31:0] expected_result(input logic [31:0] op_v,
                                                    input logic [31:0] mode_v,
                                                    input logic [31:0] x,
                                                    input logic [31:0] y);
        logic [31:0] m;
        m = (mode_v == 32'd3) ? 32'd2 : mode_v;   // code 3 acts as code 2
        if (op_v == 32'd0) begin
            if (m == 32'd0) begin
                return (x * y) / 256;
            end else if (m == 32'd1) begin
                return (x + (x * y) / 256) & 32'h1fff;   // 13-bit result wraps
            end
            return (2 * x) & 32'h1fff;
        end
        if (m == 32'd0) begin
            return (y == 32'd0) ? 32'd255 : (x * 256) / y;
        end else if ((x / 4) >= y) begin
            return (m == 32'd1) ? 32'd511 : 32'd256;   // saturation includes a zero divisor
        end
        return (m == 32'd1) ? (x * 128) / y : (x * 64) / y;
    endfunction

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    //////////////////////////////
    // one request/response pair
    //////////////////////////////
    task automatic run_op(input logic [31:0] op_v, input logic [31:0] mode_v,
                          input logic [31:0] x, input logic [31:0] y,
                          input logic [31:0] exp, input int hold);
        logic [31:0] r;
        @(posedge CLK);
        in_valid <= 1'b1;
        op       <= alu_op_t'(op_v[0]);
        mode     <= alu_mode_t'(mode_v[1:0]);
        x_in     <= operand_t'(x);
        y_in     <= operand_t'(y);
        @(negedge CLK);
        check_value("in_ready", in_ready, 32'd1);
        @(posedge CLK);                      // accepting edge
        draw_rand(r);
        in_valid <= 1'b0;
        x_in     <= r[12:0];                 // scramble operands once they are latched
        y_in     <= r[25:13];
        @(negedge CLK);
        while (!out_valid) begin
            check_value("in_ready", in_ready, 32'd0);   // busy
            @(negedge CLK);
        end
        check_value("in_ready", in_ready, 32'd0);
        check_value("result", result, exp);
        // output must stay put under back-pressure
        repeat (hold) begin
            @(negedge CLK);
            check_value("out_valid", out_valid, 32'd1);
            check_value("in_ready", in_ready, 32'd0);
            check_value("result", result, exp);
        end
        @(posedge CLK);
        out_ready <= 1'b1;
        @(posedge CLK);                      // consuming edge
        out_ready <= 1'b0;
        @(negedge CLK);
        check_value("out_valid", out_valid, 32'd0);   // exactly one result per request
        check_value("in_ready", in_ready, 32'd1);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        int          fd;
        int          n_fields;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_mode;
        logic [31:0] f_x;
        logic [31:0] f_y;
        logic [31:0] f_exp;
        logic [31:0] r;
        logic [31:0] r_op;
        logic [31:0] r_mode;
        logic [31:0] r_x;
        logic [31:0] r_y;
        RST_N     <= 1'b0;
        in_valid  <= 1'b0;
        out_ready <= 1'b0;
        op        <= op_mul;
        mode      <= '0;
        x_in      <= '0;
        y_in      <= '0;
        fd = $fopen("testbench/share_alu_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file testbench/share_alu_stim.txt");
            abort_run();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0) begin
                    // skip comment and blank lines
                    if ((line.len() > 0) && (line[0] != "#")) begin
                        n_fields = $sscanf(line, "%h %h %h %h %h",
                                           f_op, f_mode, f_x, f_y, f_exp);
                        if (n_fields == 5) begin
                            vec_op.push_back(f_op);
                            vec_mode.push_back(f_mode);
                            vec_x.push_back(f_x);
                            vec_y.push_back(f_y);
                            vec_exp.push_back(f_exp);
                        end
                    end
                end
            end
            $fclose(fd);
        end
        if (vec_op.size() == 0) begin
            $display("the stimulus file holds no vectors");
            abort_run();
        end
        stim_loaded = 1'b1;

        repeat (reset_cycles) @(posedge CLK);
        RST_N <= 1'b1;
        @(negedge CLK);
        check_value("in_ready", in_ready, 32'd1);   // idle after reset
        check_value("out_valid", out_valid, 32'd0);
        check_value("result", result, 32'd0);

        // directed vectors with expected values from the file
        foreach (vec_op[i]) begin
            draw_rand(r);
            run_op(vec_op[i], vec_mode[i], vec_x[i], vec_y[i], vec_exp[i], int'(r[2:0]));
        end

        for (int i = 0; i < n_random; i++) begin
            draw_rand(r);
            r_op   = {31'd0, r[0]};
            r_mode = {30'd0, r[2:1]};
            draw_rand(r);
            if (r_op == 32'd0) begin
                r_x = {19'd0, r[12:0]};
                r_y = {24'd0, r[20:13]};         // pure 8-bit fraction
            end else if (r_mode == 32'd0) begin
                r_y = ({16'd0, r[15:0]} % 32'd8191) + 32'd1;
                draw_rand(r);
                r_x = r % r_y;                   // sa needs x < y
            end else begin
                r_x = {19'd0, r[12:0]};
                r_y = {19'd0, r[25:13]} >> r[27:26];   // smaller divisors hit saturation
            end
            draw_rand(r);
            run_op(r_op, r_mode, r_x, r_y, expected_result(r_op, r_mode, r_x, r_y),
                   int'(r[2:0]));
        end

        if (error_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            abort_run();
        end
    end

    // watchdog sized from the number of operations
    initial begin
        wait (stim_loaded);
        repeat (reset_cycles + (vec_op.size() + n_random) * cycles_per_op) @(posedge CLK);
        $display("watchdog expired: the DUT did not finish all operations in time");
        abort_run();
    end

endmodule

/* verilog.f */
logic/alu_pkg.sv
logic/alu_step_counter.sv
logic/alu_sequencer.sv
logic/shift_add_multiplier.sv
logic/restoring_divider.sv
logic/share_alu_top.sv
testbench/tb_share_alu.sv
